// File: include/router_settings.svh
// global sizes of the five-port mesh router switch allocator
// every packet carries the same flit count, header flit included
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// width of one mesh coordinate (y or x)
`define ROUTER_COORD_W 4

// north, south, west, east and local
`define ROUTER_PORTS 5

// flits per packet, the header flit counts as the first one
`define ROUTER_PACKET_FLITS 4

`endif

// File: logic/arb_pkg.sv
// switch allocation types exchanged between route controllers and output arbiters
package arb_pkg;

	// one request per input port, it names a single output port
	typedef struct packed {
		logic                valid;    // a routed packet is waiting
		route_pkg::port_id_t out_port; // output picked by the YX route
		logic                last;     // next read takes the tail flit
	} route_req_t;

	// crossbar select of one output port
	typedef struct packed {
		logic                valid; // output locked to a source
		route_pkg::port_id_t src;   // input port feeding this output
	} xbar_grant_t;

endpackage

// File: logic/arbiter.sv
// switch allocator of a five-port mesh router, buffers and crossbar live outside
// credit_i must be high only when the downstream buffer takes a flit this cycle
`timescale 1ns/1ns
`include "router_settings.svh"

module arbiter (
	input  logic                                      clk,
	input  logic                                      arst_n_i,
	input  route_pkg::coord_t                         router_addr_i,
	input  route_pkg::in_status_t [`ROUTER_PORTS-1:0] in_status_i,
	input  logic [`ROUTER_PORTS-1:0]                  credit_i,
	output logic [`ROUTER_PORTS-1:0]                  read_o,
	output route_pkg::port_id_t [`ROUTER_PORTS-1:0]   nexthop_o,
	output arb_pkg::xbar_grant_t [`ROUTER_PORTS-1:0]  grant_o
);

	localparam int PORTS = `ROUTER_PORTS;

	arb_pkg::route_req_t [PORTS-1:0] reqs;     // one request per input
	logic [PORTS-1:0]                out_read; // read strobe per output

	// route stage, indexed by input port
	for (genvar gi = 0; gi < PORTS; gi++) begin : g_in
		input_route_ctrl u_route (
			.clk           (clk),
			.arst_n_i      (arst_n_i),
			.router_addr_i (router_addr_i),
			.status_i      (in_status_i[gi]),
			.read_i        (read_o[gi]),
			.req_o         (reqs[gi]),
			.nexthop_o     (nexthop_o[gi])
		);
	end

	// switch arbiters, indexed by output port
	for (genvar go = 0; go < PORTS; go++) begin : g_out
		rr_output_arbiter #(
			.OUT_PORT (route_pkg::port_id_t'(go))
		) u_arb (
			.clk      (clk),
			.arst_n_i (arst_n_i),
			.reqs_i   (reqs),
			.credit_i (credit_i[go]),
			.grant_o  (grant_o[go]),
			.read_o   (out_read[go])
		);
	end

	// an input asks for one output only, so at most one term is ever set
	always_comb begin
		read_o = '0;
		for (int i = 0; i < PORTS; i++) begin
			for (int o = 0; o < PORTS; o++) begin
				if (out_read[o] && (grant_o[o].src == route_pkg::port_id_t'(i))) begin
					read_o[i] = 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/input_route_ctrl.sv
// route stage of one input port, YX dimension order with fixed size packets
// a header is only taken while idle, so the buffer head must hold it by then
`timescale 1ns/1ns
`include "router_settings.svh"

module input_route_ctrl (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  route_pkg::coord_t     router_addr_i,
	input  route_pkg::in_status_t status_i,
	input  logic                  read_i,
	output arb_pkg::route_req_t   req_o,
	output route_pkg::port_id_t   nexthop_o
);

	localparam int CNT_W = ($clog2(`ROUTER_PACKET_FLITS) > 0) ?
		$clog2(`ROUTER_PACKET_FLITS) : 1;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`ROUTER_PACKET_FLITS - 1);

	route_pkg::port_id_t yx_route;   // route of the header at the buffer head
	route_pkg::port_id_t route_q;    // next-hop register
	logic                busy_q;     // a packet is being forwarded
	logic [CNT_W-1:0]    flit_cnt_q; // flits already read from this packet
	logic                load_route;
	logic                last_flit;

	// y is resolved first, x only once the row matches
	always_comb begin
		if (status_i.dest.y > router_addr_i.y) begin
			yx_route = route_pkg::PORT_N;
		end else if (status_i.dest.y < router_addr_i.y) begin
			yx_route = route_pkg::PORT_S;
		end else if (status_i.dest.x > router_addr_i.x) begin
			yx_route = route_pkg::PORT_E;
		end else if (status_i.dest.x < router_addr_i.x) begin
			yx_route = route_pkg::PORT_W;
		end else begin
			yx_route = route_pkg::PORT_L; // the packet has arrived
		end
	end

	assign load_route = ~busy_q & status_i.has_flit; // head flit is a header while idle
	assign last_flit  = busy_q & (flit_cnt_q == LAST_CNT);

	// packet tracker
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q     <= 1'b0;
			flit_cnt_q <= '0;
		end else if (load_route) begin
			busy_q     <= 1'b1;
			flit_cnt_q <= '0;
		end else if (busy_q && read_i) begin
			if (last_flit) begin
				busy_q     <= 1'b0; // tail gone, next head is a header again
				flit_cnt_q <= '0;
			end else begin
				flit_cnt_q <= flit_cnt_q + 1'b1;
			end
		end
	end

	// next-hop register, only meaningful while busy
	always_ff @(posedge clk) begin
		if (load_route) begin
			route_q <= yx_route;
		end
	end

	always_comb begin
		req_o.valid    = busy_q;
		req_o.out_port = route_q;
		req_o.last     = last_flit;
	end

	assign nexthop_o = route_q; // demux address towards the chosen output

endmodule

// File: logic/route_pkg.sv
// routing types shared by the route controllers, the arbiters and the top level
// the coordinate layout must match the header field of the head flit
`include "router_settings.svh"

package route_pkg;

	// port numbering, also the crossbar select encoding
	typedef enum logic [2:0] {
		PORT_N = 3'd0,
		PORT_S = 3'd1,
		PORT_W = 3'd2,
		PORT_E = 3'd3,
		PORT_L = 3'd4
	} port_id_t;

	// mesh position, y in the upper half
	typedef struct packed {
		logic [`ROUTER_COORD_W-1:0] y;
		logic [`ROUTER_COORD_W-1:0] x;
	} coord_t;

	// what the input buffer shows about its head flit
	typedef struct packed {
		logic   has_flit; // buffer not empty
		coord_t dest;     // destination taken from the header
	} in_status_t;

endpackage

// File: logic/rr_output_arbiter.sv
// round-robin switch arbiter of one output port, a grant lasts a whole packet
// its own input is never considered, so U-turn requests stall forever
`timescale 1ns/1ns
`include "router_settings.svh"

module rr_output_arbiter #(
	parameter route_pkg::port_id_t OUT_PORT = route_pkg::PORT_N
) (
	input  logic                                    clk,
	input  logic                                    arst_n_i,
	input  arb_pkg::route_req_t [`ROUTER_PORTS-1:0] reqs_i,
	input  logic                                    credit_i,
	output arb_pkg::xbar_grant_t                    grant_o,
	output logic                                    read_o
);

	localparam int PORTS = `ROUTER_PORTS;

	logic [PORTS-1:0]    match;      // inputs asking for this output
	logic                pick_found;
	route_pkg::port_id_t pick_id;    // winner of the round-robin search
	logic                locked_q;
	route_pkg::port_id_t owner_q;
	route_pkg::port_id_t ptr_q;      // last input served
	logic                release_pkt;

	always_comb begin
		for (int i = 0; i < PORTS; i++) begin
			match[i] = reqs_i[i].valid && (reqs_i[i].out_port == OUT_PORT) &&
				(i != int'(OUT_PORT)); // own port masked
		end
	end

	// search starts just after the pointer and wraps around
	always_comb begin : rr_search
		int idx;
		pick_found = 1'b0;
		pick_id    = ptr_q;
		for (int off = 1; off <= PORTS; off++) begin
			idx = (int'(ptr_q) + off) % PORTS;
			if (!pick_found && match[idx]) begin
				pick_found = 1'b1;
				pick_id    = route_pkg::port_id_t'(idx);
			end
		end
	end

	// the owner's tail flit leaves with this read
	assign release_pkt = read_o & reqs_i[owner_q].last;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			locked_q <= 1'b0;
			owner_q  <= route_pkg::PORT_N;
			ptr_q    <= route_pkg::PORT_L; // N comes first after reset
		end else if (!locked_q) begin
			if (pick_found) begin
				locked_q <= 1'b1;
				owner_q  <= pick_id;
				ptr_q    <= pick_id;
			end
		end else if (release_pkt) begin
			locked_q <= 1'b0; // search again from the next edge on
		end
	end

	always_comb begin
		grant_o.valid = locked_q;
		grant_o.src   = owner_q;
	end

	// one flit per cycle while downstream has room
	assign read_o = locked_q & credit_i;

endmodule

// File: run_sim.sh
#!/bin/sh
# compile the switch allocator testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module arbiter_tb -f sources.f -o arbiter_sim
./obj_dir/arbiter_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

// File: sources.f
+incdir+include
logic/route_pkg.sv
logic/arb_pkg.sv
logic/input_route_ctrl.sv
logic/rr_output_arbiter.sv
logic/arbiter.sv
test/arbiter_tb.sv

// File: test/arbiter_tb.sv
// randomized testbench for the switch allocator with the router at (y=8, x=8)
// input buffers and downstream credits are emulated here and no U-turn header is generated
`timescale 1ns/1ns
`include "router_settings.svh"

module arbiter_tb;

	localparam int PORTS   = `ROUTER_PORTS;
	localparam int FLITS   = `ROUTER_PACKET_FLITS;
	localparam int PKTS    = 20;
	localparam int TIMEOUT = 3000; // 400 flits doubled for half credit plus margin

	logic                               clk;
	logic                               arst_n_i;
	route_pkg::coord_t                  router_addr;
	route_pkg::in_status_t [PORTS-1:0]  in_status;
	logic [PORTS-1:0]                   credit;
	logic [PORTS-1:0]                   read;
	route_pkg::port_id_t [PORTS-1:0]    nexthop;
	arb_pkg::xbar_grant_t [PORTS-1:0]   grant;

	logic [15:0]       lfsr;
	route_pkg::coord_t pkt_dest [PORTS][PKTS];
	int   pkt_idx [PORTS];     // packet at the buffer head
	int   pkt_reads [PORTS];   // flits of that packet already read
	int   total_reads [PORTS];
	logic m_busy [PORTS];      // model of the route controllers
	int   m_cnt [PORTS];
	int   m_route [PORTS];
	logic m_locked [PORTS];    // model of the output arbiters
	int   m_owner [PORTS];
	int   m_ptr [PORTS];
	logic m_read_out [PORTS];
	logic m_read_in [PORTS];
	logic prev_valid [PORTS];
	int   grant_reads [PORTS]; // reads seen during the current grant of each output
	int   cycle_cnt;

	arbiter dut0 (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.router_addr_i (router_addr),
		.in_status_i   (in_status),
		.credit_i      (credit),
		.read_o        (read),
		.nexthop_o     (nexthop),
		.grant_o       (grant)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// 16-bit Galois LFSR stepped once for every bit taken
	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 16'hB400;
		end
		return b;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			v = (v << 1) | int'(next_bit());
		end
		return v;
	endfunction

	// rows are resolved before columns and equal on both means local
	function automatic int yx_port(input route_pkg::coord_t d);
		int p;
		if (d.y > router_addr.y) p = 0;
		else if (d.y < router_addr.y) p = 1;
		else if (d.x > router_addr.x) p = 3;
		else if (d.x < router_addr.x) p = 2;
		else p = 4;
		return p;
	endfunction

	function automatic logic all_done();
		logic done;
		done = 1'b1;
		for (int i = 0; i < PORTS; i++) begin
			if (total_reads[i] < PKTS * FLITS) done = 1'b0;
		end
		return done;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string test, input int exp, input int act);
		report_failure($sformatf("mismatch %s expected %0d actual %0d", test, exp, act));
	endtask

	task automatic make_packets();
		route_pkg::coord_t d;
		for (int i = 0; i < PORTS; i++) begin
			for (int p = 0; p < PKTS; p++) begin
				do begin
					d = 8'(rand_bits(8));
				end while (yx_port(d) == i); // would route back out of its own port
				pkt_dest[i][p] = d;
			end
		end
	endtask

	task automatic drive_inputs();
		for (int i = 0; i < PORTS; i++) begin
			if (pkt_idx[i] < PKTS) begin
				in_status[i].has_flit = 1'b1;
				in_status[i].dest     = pkt_dest[i][pkt_idx[i]];
			end else begin
				in_status[i] = '0; // buffer drained
			end
			credit[i] = next_bit();
		end
	endtask

	task automatic check_outputs();
		int owners;
		int src;
		for (int o = 0; o < PORTS; o++) begin
			m_read_out[o] = m_locked[o] && credit[o];
		end
		for (int i = 0; i < PORTS; i++) begin
			m_read_in[i] = 1'b0;
			for (int o = 0; o < PORTS; o++) begin
				if (m_read_out[o] && m_owner[o] == i) m_read_in[i] = 1'b1;
			end
		end
		for (int o = 0; o < PORTS; o++) begin
			assert (grant[o].valid == m_locked[o]) else report_mismatch(
				$sformatf("grant_valid[%0d]", o), int'(m_locked[o]), int'(grant[o].valid));
			if (m_locked[o]) begin
				assert (int'(grant[o].src) == m_owner[o]) else report_mismatch(
					$sformatf("grant_src[%0d]", o), m_owner[o], int'(grant[o].src));
			end
		end
		for (int i = 0; i < PORTS; i++) begin
			if (read[i]) begin
				assert (pkt_idx[i] < PKTS) else report_failure(
					$sformatf("input %0d was read while its buffer was empty", i));
			end
			assert (read[i] == m_read_in[i]) else report_mismatch(
				$sformatf("read[%0d]", i), int'(m_read_in[i]), int'(read[i]));
			if (m_busy[i]) begin
				assert (int'(nexthop[i]) == yx_port(pkt_dest[i][pkt_idx[i]])) else report_mismatch(
					$sformatf("nexthop[%0d]", i), yx_port(pkt_dest[i][pkt_idx[i]]),
					int'(nexthop[i]));
			end
			owners = 0;
			src    = 0;
			for (int o = 0; o < PORTS; o++) begin
				if (grant[o].valid && int'(grant[o].src) == i) begin
					owners++;
					src = o;
				end
			end
			assert (owners <= 1) else report_failure(
				$sformatf("input %0d is granted by %0d outputs at once", i, owners));
			if (read[i]) begin
				assert (owners == 1 && credit[src]) else report_failure(
					$sformatf("input %0d was read without a grant or without credit", i));
			end
		end
		// grant length is measured on the DUT outputs alone
		for (int o = 0; o < PORTS; o++) begin
			if (prev_valid[o] && !grant[o].valid) begin
				assert (grant_reads[o] == FLITS) else report_mismatch(
					$sformatf("grant_length[%0d]", o), FLITS, grant_reads[o]);
				grant_reads[o] = 0;
			end
			if (grant[o].valid && credit[o] && read[grant[o].src]) grant_reads[o]++;
			prev_valid[o] = grant[o].valid;
		end
	endtask

	task automatic advance_model();
		logic last [PORTS];
		logic found;
		int   start;
		int   idx;
		for (int i = 0; i < PORTS; i++) begin
			last[i] = m_busy[i] && (m_cnt[i] == FLITS - 1);
		end
		for (int o = 0; o < PORTS; o++) begin
			if (!m_locked[o]) begin
				found = 1'b0;
				start = m_ptr[o];
				for (int off = 1; off <= PORTS; off++) begin
					idx = (start + off) % PORTS;
					if (!found && m_busy[idx] && m_route[idx] == o && idx != o) begin
						found       = 1'b1;
						m_locked[o] = 1'b1;
						m_owner[o]  = idx;
						m_ptr[o]    = idx;
					end
				end
			end else if (m_read_out[o] && last[m_owner[o]]) begin
				m_locked[o] = 1'b0;
			end
		end
		for (int i = 0; i < PORTS; i++) begin
			if (!m_busy[i] && pkt_idx[i] < PKTS) begin
				m_busy[i]  = 1'b1;
				m_cnt[i]   = 0;
				m_route[i] = yx_port(pkt_dest[i][pkt_idx[i]]);
			end else if (m_busy[i] && m_read_in[i]) begin
				if (last[i]) begin
					m_busy[i] = 1'b0;
					m_cnt[i]  = 0;
				end else begin
					m_cnt[i]++;
				end
			end
			if (m_read_in[i]) begin
				pkt_reads[i]++;
				total_reads[i]++;
				if (pkt_reads[i] == FLITS) begin
					pkt_reads[i] = 0;
					pkt_idx[i]++; // next header reaches the buffer head
				end
			end
		end
	endtask

	initial begin
		arst_n_i      = 1'b0;
		lfsr          = 16'd22;
		router_addr.y = 4'd8;
		router_addr.x = 4'd8;
		in_status     = '0;
		credit        = '0;
		cycle_cnt     = 0;
		for (int i = 0; i < PORTS; i++) begin
			pkt_idx[i]     = 0;
			pkt_reads[i]   = 0;
			total_reads[i] = 0;
			m_busy[i]      = 1'b0;
			m_cnt[i]       = 0;
			m_route[i]     = 0;
			m_locked[i]    = 1'b0;
			m_owner[i]     = 0;
			m_ptr[i]       = 4; // pointer at L so N is searched first
			prev_valid[i]  = 1'b0;
			grant_reads[i] = 0;
		end
		make_packets();
		@(posedge clk);
		@(posedge clk);
		#3;
		assert (read == '0) else report_mismatch("reset_read", 0, int'(read));
		for (int o = 0; o < PORTS; o++) begin
			assert (!grant[o].valid) else report_mismatch(
				$sformatf("reset_grant_valid[%0d]", o), 0, int'(grant[o].valid));
		end
		@(posedge clk);
		@(posedge clk);
		#1;
		arst_n_i = 1'b1;
		drive_inputs();
		while (!all_done()) begin
			#2;
			check_outputs();
			advance_model();
			cycle_cnt++;
			assert (cycle_cnt < TIMEOUT) else report_failure(
				$sformatf("timeout after %0d cycles with packets still queued", cycle_cnt));
			@(posedge clk);
			#1;
			drive_inputs();
		end
		#2;
		check_outputs(); // the last grants release here
		$display("TESTS PASSED");
		$finish;
	end

endmodule
